// File: vtxCsr_cfg.svh
`ifndef VTX_CSR_CFG_SVH
`define VTX_CSR_CFG_SVH

// block select on address bits 15..12
`define VTX_BLOCK_ID		4'h4

// bus and field widths
`define VTX_APB_ADDR_W		16
`define VTX_APB_DATA_W		32
`define VTX_REG_OFS_W		12
`define VTX_DMA_ADDR_W		19
`define VTX_COLOR_W			16
`define VTX_XCOORD_W		12
`define VTX_YCOORD_W		12
`define VTX_MAP_SIZE_W		8
`define VTX_FRAME_TIMING_W	7

// rectangle bank, stride of five words per rectangle
`define VTX_NUM_SQUARES		5
`define VTX_SQ_FIELDS		5
`define VTX_SQ_COLOR		3'd0
`define VTX_SQ_LEFT			3'd1
`define VTX_SQ_RIGHT		3'd2
`define VTX_SQ_TOP			3'd3
`define VTX_SQ_BOTTOM		3'd4

// reset values
`define VTX_MAP_X_RST		8'd30		// 480 px / 16 px tiles
`define VTX_MAP_Y_RST		8'd17		// 272 px / 16 px tiles
`define VTX_DMA_END_RST		19'h7FFFF
`define VTX_SC_CTRL_RST		3'b100		// fader held in local reset

// register offsets inside the block
`define VTX_OFS_DMA_EN		12'h004
`define VTX_OFS_DMA_CYC		12'h008
`define VTX_OFS_DMA_START	12'h00C
`define VTX_OFS_DMA_END		12'h010
`define VTX_OFS_DMA_STEP	12'h014
`define VTX_OFS_MAP			12'h100
`define VTX_OFS_SQ_BASE		12'h200
`define VTX_OFS_SC_COLOR	12'h300
`define VTX_OFS_SC_TIMING	12'h301
`define VTX_OFS_SC_CTRL		12'h302
`define VTX_OFS_SC_STAT		12'h303

`endif

// File: vtxCsrPkg.sv
`include "vtxCsr_cfg.svh"

package vtxCsrPkg;

	//--------------------------------------------------------------------------
	// bus side
	//--------------------------------------------------------------------------
	typedef logic [`VTX_APB_ADDR_W-1:0]		apbAddrT;
	typedef logic [`VTX_APB_DATA_W-1:0]		apbDataT;
	typedef logic [`VTX_REG_OFS_W-1:0]		regOffsetT;	// low address bits

	//--------------------------------------------------------------------------
	// register fields
	//--------------------------------------------------------------------------
	typedef logic [`VTX_DMA_ADDR_W-1:0]		dmaAddrT;		// word address
	typedef logic [`VTX_COLOR_W-1:0]		colorT;
	typedef logic signed [`VTX_XCOORD_W-1:0]	xCoordT;	// may go off screen left
	typedef logic signed [`VTX_YCOORD_W-1:0]	yCoordT;
	typedef logic [`VTX_MAP_SIZE_W-1:0]		mapSizeT;		// in tiles
	typedef logic [`VTX_FRAME_TIMING_W-1:0]	frameTimingT;

	// slave phase, one wait state per transfer
	typedef enum logic [1:0]
	{
		apbIdle,
		apbWait,
		apbAck
	} apbPhaseT;

endpackage

// File: vtxApbPort.sv
`timescale 1ns/1ns
`include "vtxCsr_cfg.svh"

module vtxApbPort
(
	input  logic					iSCLK,
	input  logic					iSRST,
	// apb slave
	input  logic					apbSel,
	input  logic					apbEnable,
	input  logic					apbWrite,
	input  vtxCsrPkg::apbAddrT		apbAddr,
	input  vtxCsrPkg::apbDataT		apbWdata,
	output vtxCsrPkg::apbDataT		apbRdata,
	output logic					apbReady,
	output logic					apbSlvErr,
	// shared lines to the register groups
	output vtxCsrPkg::regOffsetT	regOffset,
	output vtxCsrPkg::apbDataT		regWdata,
	output logic					regWrite,
	output logic					regIsWrite,
	input  logic					anyHit,
	input  vtxCsrPkg::apbDataT		mergedRdata
);

import vtxCsrPkg::*;

apbPhaseT	phase;
logic		blockHit;
logic		accessErr;
logic		sample;

assign blockHit  = (apbAddr[`VTX_APB_ADDR_W-1:`VTX_REG_OFS_W] == `VTX_BLOCK_ID);
assign accessErr = ~(blockHit & anyHit);		// wrong block or nobody claims it
assign sample    = (phase == apbWait) & apbSel & apbEnable;

//--------------------------------------------------------------------------
// phase machine
//--------------------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		phase     <= apbIdle;
		apbSlvErr <= 1'b0;
	end
	else
	begin
		case (phase)
			apbIdle:
			begin
				if (apbSel)
					phase <= apbWait;		// setup cycle seen
			end
			apbWait:
			begin
				if (sample)
				begin
					phase     <= apbAck;
					apbSlvErr <= accessErr;
				end
				else if (!apbSel)
					phase <= apbIdle;		// master dropped the transfer
			end
			default:
			begin
				phase     <= apbIdle;
				apbSlvErr <= 1'b0;
			end
		endcase
	end
end

// read data captured at the sample cycle
always_ff @(posedge iSCLK)
begin
	if (iSRST)
		apbRdata <= '0;
	else if (sample)
		apbRdata <= accessErr ? '0 : mergedRdata;
end

assign apbReady = (phase == apbAck);

//--------------------------------------------------------------------------
// group side
//--------------------------------------------------------------------------
assign regOffset  = apbAddr[`VTX_REG_OFS_W-1:0];
assign regWdata   = apbWdata;
assign regIsWrite = apbWrite;
assign regWrite   = apbReady & apbWrite & ~apbSlvErr;	// one cycle, ack phase only

endmodule

// File: vtxDmaRegs.sv
`timescale 1ns/1ns
`include "vtxCsr_cfg.svh"

module vtxDmaRegs
(
	input  logic					iSCLK,
	input  logic					iSRST,
	input  vtxCsrPkg::regOffsetT	regOffset,
	input  vtxCsrPkg::apbDataT		regWdata,
	input  logic					regWrite,
	input  logic					regIsWrite,
	output vtxCsrPkg::apbDataT		groupRdata,
	output logic					groupHit,
	// dma engine
	input  logic					dmaDone,
	output logic					dmaEnable,
	output logic					dmaCycleEnable,
	output vtxCsrPkg::dmaAddrT		dmaAddrStart,
	output vtxCsrPkg::dmaAddrT		dmaAddrEnd,
	output vtxCsrPkg::dmaAddrT		dmaAddrStep
);

import vtxCsrPkg::*;

logic	selEn;
logic	selCyc;
logic	selStart;
logic	selEnd;
logic	selStep;

assign selEn    = (regOffset == `VTX_OFS_DMA_EN);
assign selCyc   = (regOffset == `VTX_OFS_DMA_CYC);
assign selStart = (regOffset == `VTX_OFS_DMA_START);
assign selEnd   = (regOffset == `VTX_OFS_DMA_END);
assign selStep  = (regOffset == `VTX_OFS_DMA_STEP);
assign groupHit = selEn | selCyc | selStart | selEnd | selStep;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		dmaEnable      <= 1'b0;
		dmaCycleEnable <= 1'b0;
		dmaAddrStart   <= '0;
		dmaAddrEnd     <= `VTX_DMA_END_RST;
		dmaAddrStep    <= '0;
	end
	else
	begin
		// end of frame reloads enable, auto-cycle keeps it running
		if (dmaDone)
			dmaEnable <= dmaCycleEnable;
		else if (regWrite & selEn)
			dmaEnable <= regWdata[0];
		if (regWrite & selCyc)
			dmaCycleEnable <= regWdata[0];
		if (regWrite & selStart)
			dmaAddrStart <= regWdata[`VTX_DMA_ADDR_W-1:0];
		if (regWrite & selEnd)
			dmaAddrEnd <= regWdata[`VTX_DMA_ADDR_W-1:0];
		if (regWrite & selStep)
			dmaAddrStep <= regWdata[`VTX_DMA_ADDR_W-1:0];
	end
end

// readback, zero-extended
always_comb
begin
	groupRdata = '0;
	if (!regIsWrite)
	begin
		case (regOffset)
			`VTX_OFS_DMA_EN:	groupRdata = apbDataT'(dmaEnable);
			`VTX_OFS_DMA_CYC:	groupRdata = apbDataT'(dmaCycleEnable);
			`VTX_OFS_DMA_START:	groupRdata = apbDataT'(dmaAddrStart);
			`VTX_OFS_DMA_END:	groupRdata = apbDataT'(dmaAddrEnd);
			`VTX_OFS_DMA_STEP:	groupRdata = apbDataT'(dmaAddrStep);
			default:			groupRdata = '0;
		endcase
	end
end

endmodule

// File: vtxSquareRegs.sv
`timescale 1ns/1ns
`include "vtxCsr_cfg.svh"

module vtxSquareRegs
(
	input  logic					iSCLK,
	input  logic					iSRST,
	input  vtxCsrPkg::regOffsetT	regOffset,
	input  vtxCsrPkg::apbDataT		regWdata,
	input  logic					regWrite,
	input  logic					regIsWrite,
	output vtxCsrPkg::apbDataT		groupRdata,
	output logic					groupHit,
	// map info
	output vtxCsrPkg::mapSizeT		mapXSize,
	output vtxCsrPkg::mapSizeT		mapYSize,
	// rectangle drawer
	output vtxCsrPkg::colorT		squareColor [`VTX_NUM_SQUARES],
	output vtxCsrPkg::xCoordT		squareLeft [`VTX_NUM_SQUARES],
	output vtxCsrPkg::xCoordT		squareRight [`VTX_NUM_SQUARES],
	output vtxCsrPkg::yCoordT		squareTop [`VTX_NUM_SQUARES],
	output vtxCsrPkg::yCoordT		squareBottom [`VTX_NUM_SQUARES]
);

import vtxCsrPkg::*;

localparam int idxW = $clog2(`VTX_NUM_SQUARES);

logic				mapSel;
regOffsetT			sqRel;
logic				sqHit;
logic [idxW-1:0]	sqIdx;
logic [2:0]			sqField;

assign mapSel   = (regOffset == `VTX_OFS_MAP);
assign sqRel    = regOffset - `VTX_OFS_SQ_BASE;		// wraps high below the base
assign groupHit = mapSel | sqHit;

//--------------------------------------------------------------------------
// offset split, rectangle n field f at base + 5n + f
//--------------------------------------------------------------------------
always_comb
begin
	sqHit   = 1'b0;
	sqIdx   = '0;
	sqField = '0;
	for (int n = 0; n < `VTX_NUM_SQUARES; n++)
	begin
		if (sqRel >= regOffsetT'(n * `VTX_SQ_FIELDS) &&
			sqRel < regOffsetT'((n + 1) * `VTX_SQ_FIELDS))
		begin
			sqHit   = 1'b1;
			sqIdx   = idxW'(n);
			sqField = 3'(sqRel - regOffsetT'(n * `VTX_SQ_FIELDS));
		end
	end
end

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		mapXSize <= `VTX_MAP_X_RST;
		mapYSize <= `VTX_MAP_Y_RST;
		for (int n = 0; n < `VTX_NUM_SQUARES; n++)
		begin
			squareColor[n]  <= '0;
			squareLeft[n]   <= '0;
			squareRight[n]  <= '0;
			squareTop[n]    <= '0;
			squareBottom[n] <= '0;
		end
	end
	else
	begin
		if (regWrite & mapSel)
			{mapXSize, mapYSize} <= regWdata[2*`VTX_MAP_SIZE_W-1:0];	// x high, y low
		if (regWrite & sqHit)
		begin
			case (sqField)
				`VTX_SQ_COLOR:	squareColor[sqIdx]  <= regWdata[`VTX_COLOR_W-1:0];
				`VTX_SQ_LEFT:	squareLeft[sqIdx]   <= regWdata[`VTX_XCOORD_W-1:0];
				`VTX_SQ_RIGHT:	squareRight[sqIdx]  <= regWdata[`VTX_XCOORD_W-1:0];
				`VTX_SQ_TOP:	squareTop[sqIdx]    <= regWdata[`VTX_YCOORD_W-1:0];
				`VTX_SQ_BOTTOM:	squareBottom[sqIdx] <= regWdata[`VTX_YCOORD_W-1:0];
			endcase
		end
	end
end

// coordinates come back as raw 12 bit fields, no sign extension
always_comb
begin
	groupRdata = '0;
	if (!regIsWrite)
	begin
		if (mapSel)
			groupRdata = apbDataT'({mapXSize, mapYSize});
		else if (sqHit)
		begin
			case (sqField)
				`VTX_SQ_COLOR:	groupRdata = apbDataT'(squareColor[sqIdx]);
				`VTX_SQ_LEFT:	groupRdata = apbDataT'($unsigned(squareLeft[sqIdx]));
				`VTX_SQ_RIGHT:	groupRdata = apbDataT'($unsigned(squareRight[sqIdx]));
				`VTX_SQ_TOP:	groupRdata = apbDataT'($unsigned(squareTop[sqIdx]));
				`VTX_SQ_BOTTOM:	groupRdata = apbDataT'($unsigned(squareBottom[sqIdx]));
				default:		groupRdata = '0;
			endcase
		end
	end
end

endmodule

// File: vtxSceneRegs.sv
`timescale 1ns/1ns
`include "vtxCsr_cfg.svh"

module vtxSceneRegs
(
	input  logic					iSCLK,
	input  logic					iSRST,
	input  vtxCsrPkg::regOffsetT	regOffset,
	input  vtxCsrPkg::apbDataT		regWdata,
	input  logic					regWrite,
	input  logic					regIsWrite,
	output vtxCsrPkg::apbDataT		groupRdata,
	output logic					groupHit,
	// scene fader
	output vtxCsrPkg::colorT		sceneColor,
	output vtxCsrPkg::frameTimingT	sceneFrameTiming,
	output logic					sceneAddEn,
	output logic					sceneSubEn,
	output logic					sceneFrameRst,
	input  logic					sceneAlphaMax,
	input  logic					sceneAlphaMin
);

import vtxCsrPkg::*;

logic	selColor;
logic	selTiming;
logic	selCtrl;
logic	selStat;

assign selColor  = (regOffset == `VTX_OFS_SC_COLOR);
assign selTiming = (regOffset == `VTX_OFS_SC_TIMING);
assign selCtrl   = (regOffset == `VTX_OFS_SC_CTRL);
assign selStat   = (regOffset == `VTX_OFS_SC_STAT);
assign groupHit  = selColor | selTiming | selCtrl | (selStat & ~regIsWrite);	// status is read only

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		sceneColor       <= '0;
		sceneFrameTiming <= '0;
		{sceneFrameRst, sceneSubEn, sceneAddEn} <= `VTX_SC_CTRL_RST;
	end
	else
	begin
		if (regWrite & selColor)
			sceneColor <= regWdata[`VTX_COLOR_W-1:0];
		if (regWrite & selTiming)
			sceneFrameTiming <= regWdata[`VTX_FRAME_TIMING_W-1:0];
		if (regWrite & selCtrl)
			{sceneFrameRst, sceneSubEn, sceneAddEn} <= regWdata[2:0];
	end
end

// alpha flags pass straight through, sampled by the port
always_comb
begin
	groupRdata = '0;
	if (!regIsWrite)
	begin
		case (1'b1)
			selColor:	groupRdata = apbDataT'(sceneColor);
			selTiming:	groupRdata = apbDataT'(sceneFrameTiming);
			selCtrl:	groupRdata = apbDataT'({sceneFrameRst, sceneSubEn, sceneAddEn});
			selStat:	groupRdata = apbDataT'({sceneAlphaMax, sceneAlphaMin});
			default:	groupRdata = '0;
		endcase
	end
end

endmodule

// File: vtxCsrTop.sv
`timescale 1ns/1ns
`include "vtxCsr_cfg.svh"

module vtxCsrTop
(
	input  logic					iSCLK,
	input  logic					iSRST,
	// apb slave
	input  logic					apbSel,
	input  logic					apbEnable,
	input  logic					apbWrite,
	input  vtxCsrPkg::apbAddrT		apbAddr,
	input  vtxCsrPkg::apbDataT		apbWdata,
	output vtxCsrPkg::apbDataT		apbRdata,
	output logic					apbReady,
	output logic					apbSlvErr,
	// dma
	input  logic					dmaDone,
	output logic					dmaEnable,
	output logic					dmaCycleEnable,
	output vtxCsrPkg::dmaAddrT		dmaAddrStart,
	output vtxCsrPkg::dmaAddrT		dmaAddrEnd,
	output vtxCsrPkg::dmaAddrT		dmaAddrStep,
	// map and rectangles
	output vtxCsrPkg::mapSizeT		mapXSize,
	output vtxCsrPkg::mapSizeT		mapYSize,
	output vtxCsrPkg::colorT		squareColor [`VTX_NUM_SQUARES],
	output vtxCsrPkg::xCoordT		squareLeft [`VTX_NUM_SQUARES],
	output vtxCsrPkg::xCoordT		squareRight [`VTX_NUM_SQUARES],
	output vtxCsrPkg::yCoordT		squareTop [`VTX_NUM_SQUARES],
	output vtxCsrPkg::yCoordT		squareBottom [`VTX_NUM_SQUARES],
	// scene change
	output vtxCsrPkg::colorT		sceneColor,
	output vtxCsrPkg::frameTimingT	sceneFrameTiming,
	output logic					sceneAddEn,
	output logic					sceneSubEn,
	output logic					sceneFrameRst,
	input  logic					sceneAlphaMax,
	input  logic					sceneAlphaMin
);

import vtxCsrPkg::*;

regOffsetT	regOffset;
apbDataT	regWdata;
logic		regWrite;
logic		regIsWrite;
logic		anyHit;
apbDataT	mergedRdata;
logic		dmaHit;
logic		squareHit;
logic		sceneHit;
apbDataT	dmaRdata;
apbDataT	squareRdata;
apbDataT	sceneRdata;

// groups return zero when not hit, so a plain OR merges them
assign anyHit      = dmaHit | squareHit | sceneHit;
assign mergedRdata = dmaRdata | squareRdata | sceneRdata;

vtxApbPort i_vtxApbPort (.*);

vtxDmaRegs i_vtxDmaRegs (.groupRdata(dmaRdata), .groupHit(dmaHit), .*);

vtxSquareRegs i_vtxSquareRegs (.groupRdata(squareRdata), .groupHit(squareHit), .*);

vtxSceneRegs i_vtxSceneRegs (.groupRdata(sceneRdata), .groupHit(sceneHit), .*);

endmodule

// File: vtxCsrTb.sv
`timescale 1ns/1ns
`include "vtxCsr_cfg.svh"

module vtxCsrTb;

import vtxCsrPkg::*;

logic			iSCLK;
logic			iSRST;
logic			apbSel;
logic			apbEnable;
logic			apbWrite;
apbAddrT		apbAddr;
apbDataT		apbWdata;
apbDataT		apbRdata;
logic			apbReady;
logic			apbSlvErr;
logic			dmaDone;
logic			dmaEnable;
logic			dmaCycleEnable;
dmaAddrT		dmaAddrStart;
dmaAddrT		dmaAddrEnd;
dmaAddrT		dmaAddrStep;
mapSizeT		mapXSize;
mapSizeT		mapYSize;
colorT			squareColor [`VTX_NUM_SQUARES];
xCoordT			squareLeft [`VTX_NUM_SQUARES];
xCoordT			squareRight [`VTX_NUM_SQUARES];
yCoordT			squareTop [`VTX_NUM_SQUARES];
yCoordT			squareBottom [`VTX_NUM_SQUARES];
colorT			sceneColor;
frameTimingT	sceneFrameTiming;
logic			sceneAddEn;
logic			sceneSubEn;
logic			sceneFrameRst;
logic			sceneAlphaMax;
logic			sceneAlphaMin;

string			testName;
logic [31:0]	lfsr;
regOffsetT		regList [$];			// every read/write register
apbDataT		shadow [0:4095];		// expected contents by offset

vtxCsrTop i_vtxCsrTop (.*);

always #2 iSCLK = ~iSCLK;

//--------------------------------------------------------------------------
// helpers
//--------------------------------------------------------------------------
task automatic checkValue(input string what, input logic [31:0] expected,
	input logic [31:0] actual);
	if (expected !== actual)
	begin
		$display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
			testName, what, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first mismatch");
	end
endtask

// galois lfsr, one step per bit
function automatic logic [31:0] randomBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		v = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

function automatic apbAddrT regAddr(input regOffsetT ofs);
	return {`VTX_BLOCK_ID, ofs};
endfunction

function automatic apbDataT fieldMask(input regOffsetT ofs);
	int k;
	k = int'(ofs) - 'h200;
	if (ofs == 12'h004 || ofs == 12'h008)
		return 32'h1;
	if (ofs < 12'h100)
		return 32'h7_FFFF;		// dma addresses
	if (ofs == 12'h301)
		return 32'h7F;
	if (ofs == 12'h302)
		return 32'h7;
	if (ofs == 12'h100 || ofs == 12'h300 || k % 5 == 0)
		return 32'hFFFF;
	return 32'hFFF;				// coordinates
endfunction

function automatic apbDataT portValue(input regOffsetT ofs);
	int k;
	k = int'(ofs) - 'h200;
	case (ofs)
		12'h004:	return dmaEnable;
		12'h008:	return dmaCycleEnable;
		12'h00C:	return dmaAddrStart;
		12'h010:	return dmaAddrEnd;
		12'h014:	return dmaAddrStep;
		12'h100:	return {mapXSize, mapYSize};
		12'h300:	return sceneColor;
		12'h301:	return sceneFrameTiming;
		12'h302:	return {sceneFrameRst, sceneSubEn, sceneAddEn};
		default:
			case (k % 5)
				0:			return squareColor[k / 5];
				1:			return $unsigned(squareLeft[k / 5]);
				2:			return $unsigned(squareRight[k / 5]);
				3:			return $unsigned(squareTop[k / 5]);
				default:	return $unsigned(squareBottom[k / 5]);
			endcase
	endcase
endfunction

task automatic loadResetModel();
	for (int k = 'h004; k <= 'h014; k += 4)
		regList.push_back(regOffsetT'(k));
	regList.push_back(12'h100);
	for (int k = 0; k < 5 * `VTX_NUM_SQUARES; k++)
		regList.push_back(regOffsetT'('h200 + k));
	for (int k = 'h300; k <= 'h302; k++)
		regList.push_back(regOffsetT'(k));
	foreach (regList[i])
		shadow[regList[i]] = '0;
	shadow[12'h010] = 32'h7_FFFF;
	shadow[12'h100] = 32'h1E11;		// 30 by 17 tiles
	shadow[12'h302] = 32'h4;
endtask

//--------------------------------------------------------------------------
// apb master
//--------------------------------------------------------------------------
task automatic runTransfer(input logic write, input apbAddrT addr, input apbDataT wdata,
	input logic doneAtAck, output apbDataT rdata, output logic err);
	int waited;
	@(negedge iSCLK);
	apbSel    = 1'b1;		// setup
	apbEnable = 1'b0;
	apbWrite  = write;
	apbAddr   = addr;
	apbWdata  = wdata;
	@(negedge iSCLK);
	apbEnable = 1'b1;
	waited    = 1;
	while (!apbReady)
	begin
		if (waited > 20)
		begin
			$display("apbReady never came for address 0x%0h", addr);
			$display("STATUS: FAIL");
			$fatal(1, "transfer timed out");
		end
		@(negedge iSCLK);
		waited++;
	end
	checkValue("ack latency", 2, waited);
	rdata     = apbRdata;
	err       = apbSlvErr;
	apbSel    = 1'b0;
	apbEnable = 1'b0;
	dmaDone   = doneAtAck;	// lands in the write pulse cycle
	@(negedge iSCLK);
	dmaDone   = 1'b0;
endtask

task automatic apbWriteWord(input apbAddrT addr, input apbDataT data, output logic err);
	apbDataT ignored;
	runTransfer(1'b1, addr, data, 1'b0, ignored, err);
endtask

task automatic apbReadWord(input apbAddrT addr, output apbDataT data, output logic err);
	runTransfer(1'b0, addr, '0, 1'b0, data, err);
endtask

task automatic writeChecked(input regOffsetT ofs, input apbDataT data);
	logic err;
	apbWriteWord(regAddr(ofs), data, err);
	checkValue($sformatf("write error flag 0x%0h", ofs), 0, err);
	shadow[ofs] = data & fieldMask(ofs);
endtask

task automatic checkAllRegs();
	apbDataT data;
	logic err;
	foreach (regList[i])
	begin
		apbReadWord(regAddr(regList[i]), data, err);
		checkValue($sformatf("read error flag 0x%0h", regList[i]), 0, err);
		checkValue($sformatf("read 0x%0h", regList[i]), shadow[regList[i]], data);
		checkValue($sformatf("port of 0x%0h", regList[i]), shadow[regList[i]],
			portValue(regList[i]));
	end
endtask

task automatic pulseDone();
	@(negedge iSCLK);
	dmaDone = 1'b1;
	@(negedge iSCLK);
	dmaDone = 1'b0;
endtask

//--------------------------------------------------------------------------
// tests
//--------------------------------------------------------------------------
task automatic resetValues();
	testName = "resetValues";
	checkValue("ready after reset", 0, apbReady);
	checkValue("slave error after reset", 0, apbSlvErr);
	checkValue("read data after reset", 0, apbRdata);
	checkAllRegs();
endtask

task automatic registerRoundTrip();
	testName = "registerRoundTrip";
	foreach (regList[i])
		writeChecked(regList[i], randomBits(32));
	checkAllRegs();
endtask

task automatic dmaReload();
	apbDataT data;
	logic err;
	testName = "dmaReload";
	writeChecked(12'h008, 32'h1);
	writeChecked(12'h004, 32'h1);
	pulseDone();
	checkValue("enable kept by auto-cycle", 1, dmaEnable);
	writeChecked(12'h008, 32'h0);
	pulseDone();
	checkValue("enable cleared by done", 0, dmaEnable);
	runTransfer(1'b1, regAddr(12'h004), 32'h1, 1'b1, data, err);
	checkValue("write error flag", 0, err);
	checkValue("done wins over write", 0, dmaEnable);
	shadow[12'h004] = '0;
	checkAllRegs();
endtask

task automatic statusReadback();
	apbDataT data;
	logic err;
	testName = "statusReadback";
	for (int f = 0; f < 4; f++)
	begin
		@(negedge iSCLK);
		{sceneAlphaMax, sceneAlphaMin} = 2'(f);
		apbReadWord(regAddr(12'h303), data, err);
		checkValue("status error flag", 0, err);
		checkValue($sformatf("flags %0d", f), f, data);
	end
	apbWriteWord(regAddr(12'h303), randomBits(32), err);
	checkValue("status write error flag", 1, err);
	checkAllRegs();
endtask

task automatic errorAccess();
	apbAddrT badAddr [3];
	apbDataT data;
	logic err;
	testName = "errorAccess";
	writeChecked(12'h014, 32'h5_A5A5);	// nonzero data behind the foreign block offset
	badAddr[0] = {4'h5, 12'h014};		// neighbour block
	badAddr[1] = regAddr(12'h018);
	badAddr[2] = regAddr(regOffsetT'('h200 + 5 * `VTX_NUM_SQUARES));
	foreach (badAddr[i])
	begin
		apbReadWord(badAddr[i], data, err);
		checkValue($sformatf("read error flag 0x%0h", badAddr[i]), 1, err);
		checkValue($sformatf("read data 0x%0h", badAddr[i]), 0, data);
		apbWriteWord(badAddr[i], randomBits(32), err);
		checkValue($sformatf("write error flag 0x%0h", badAddr[i]), 1, err);
	end
	checkAllRegs();
endtask

initial
begin
	iSCLK         = 1'b0;
	iSRST         = 1'b1;
	apbSel        = 1'b0;
	apbEnable     = 1'b0;
	apbWrite      = 1'b0;
	apbAddr       = '0;
	apbWdata      = '0;
	dmaDone       = 1'b0;
	sceneAlphaMax = 1'b0;
	sceneAlphaMin = 1'b0;
	lfsr          = 32'h3a8f_0252;
	testName      = "reset";
	loadResetModel();
	repeat (4) @(posedge iSCLK);
	@(negedge iSCLK);
	iSRST = 1'b0;
	resetValues();
	registerRoundTrip();
	dmaReload();
	statusReadback();
	errorAccess();
	$display("STATUS: PASS");
	$finish;
end

endmodule

// File: compile.f
+incdir+.
vtxCsrPkg.sv
vtxApbPort.sv
vtxDmaRegs.sv
vtxSquareRegs.sv
vtxSceneRegs.sv
vtxCsrTop.sv
vtxCsrTb.sv

// File: Bender.yml
package:
  name: vtxCsr

export_include_dirs:
  - .

sources:
  - vtxCsrPkg.sv
  - vtxApbPort.sv
  - vtxDmaRegs.sv
  - vtxSquareRegs.sv
  - vtxSceneRegs.sv
  - vtxCsrTop.sv
  - target: simulation
    files:
      - vtxCsrTb.sv
